/* vlog.f */
+incdir+design
design/batchDataPkg.sv
design/batchSchedPkg.sv
design/dualPortRam.sv
design/bitLut.sv
design/complexRecursion.sv
design/channelPath.sv
design/batchSchedule.sv
design/batchFilterTop.sv
tests/batchFilter_checker.sv
tests/batchFilterTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = batchFilterTb
FILELIST  = vlog.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)
PASS_MSG  = All tests passed

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* tests/batchFilterTb.sv */
`timescale 1ns/1ns
`include "batch_consts.svh"

module batchFilterTb;
    import batchDataPkg::*;

    localparam int BD            = `BATCH_DEPTH;
    // Lookahead batch, compute batch, reorder batch and pipeline stages
    localparam int LATENCY       = 4 * `BATCH_DEPTH + 4;
    localparam int RESET_CYCLES  = 5;
    localparam int MAX_WORDS     = 256;
    localparam int VALID_TIMEOUT = 2 * LATENCY;
    localparam int IMPULSE_WORD  = 5 * `BATCH_DEPTH + 3;
    localparam int MODE_ZERO     = 0;
    localparam int MODE_IMPULSE  = 1;
    localparam int MODE_RANDOM   = 2;

    logic       clkDS;
    logic       rst;
    sampleWordT bitsIn;
    resultT     result;
    logic       resultValid;

    sampleWordT stim [MAX_WORDS];
    int         curCycle = -1;
    int         checkLimit = 0;
    string      testName = "idle";
    int         checkCount = 0;
    int         errorCount = 0;
    int         timeoutCount = 0;

    batchFilterTop i_dut (
        .clkDS(clkDS), .rst(rst), .bits_i(bitsIn),
        .result_o(result), .resultValid_o(resultValid)
    );

    initial begin
        clkDS = 1'b0;
        forever #20 clkDS = ~clkDS;
    end

    task automatic checkValue(string name, logic signed [63:0] expected,
                              logic signed [63:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Error: %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    function automatic partT truncProduct(partT a, partT b);
        longint full;
        full = longint'(a) * longint'(b);
        return partT'(full >>> `FRAC_W);
    endfunction

    function automatic cplxT complexProduct(cplxT a, cplxT b);
        cplxT p;
        p.re = truncProduct(a.re, b.re) - truncProduct(a.im, b.im);
        p.im = truncProduct(a.re, b.im) + truncProduct(a.im, b.re);
        return p;
    endfunction

    function automatic cplxT cplxSum(cplxT a, cplxT b);
        cplxT s;
        s.re = a.re + b.re;
        s.im = a.im + b.im;
        return s;
    endfunction

    // Backward direction sees the newest bit of a word first
    function automatic cplxT wordContribution(int ch, logic dir, logic [`OSR-1:0] word);
        cplxT acc;
        cplxT w;
        logic sel;
        acc = '0;
        for (int i = 0; i < `OSR; i++) begin
            sel = dir ? word[`OSR-1-i] : word[i];
            if (sel) begin
                w = bitWeight(ch, dir, i);
                acc = cplxSum(acc, w);
            end
        end
        return acc;
    endfunction

    function automatic resultT expectedResult(int t);
        int     first;
        int     pos;
        cplxT   fwd;
        cplxT   ahead;
        cplxT   back;
        cplxT   fwdOut;
        cplxT   bwdOut;
        resultT total;
        first = (t / BD) * BD;
        pos = t % BD;
        total = '0;
        for (int ch = 0; ch < `N_CHAN; ch++) begin
            fwd = '0;
            for (int k = 0; k <= t; k++) begin
                fwd = cplxSum(complexProduct(lfPow[ch], fwd),
                              wordContribution(ch, 1'b0, stim[k][ch]));
            end
            // Lookahead over the next batch from zero
            ahead = '0;
            for (int j = BD - 1; j >= 0; j--) begin
                ahead = cplxSum(complexProduct(lbPow[ch], ahead),
                                wordContribution(ch, 1'b1, stim[first + BD + j][ch]));
            end
            // Backward starts from the lookahead with no decay on the first word
            back = cplxSum(ahead, wordContribution(ch, 1'b1, stim[first + BD - 1][ch]));
            for (int j = BD - 2; j >= pos; j--) begin
                back = cplxSum(complexProduct(lbPow[ch], back),
                               wordContribution(ch, 1'b1, stim[first + j][ch]));
            end
            fwdOut = complexProduct(wf[ch], fwd);
            bwdOut = complexProduct(wb[ch], back);
            total = total + resultT'(fwdOut.re) + resultT'(bwdOut.re);
        end
        return total;
    endfunction

    function automatic void fillStimulus(int mode);
        for (int k = 0; k < MAX_WORDS; k++) begin
            stim[k] = (mode == MODE_RANDOM) ? sampleWordT'($urandom) : '0;
        end
        if (mode == MODE_IMPULSE) begin
            stim[IMPULSE_WORD][`N_CHAN-1][2] = 1'b1;
        end
    endfunction

    task automatic driveCycle();
        @(posedge clkDS);
        curCycle++;
        if (curCycle < MAX_WORDS) begin
            bitsIn <= stim[curCycle];
        end else begin
            bitsIn <= '0;
        end
    endtask

    // Word 0 goes out on the same edge that releases reset
    task automatic startPhase(string name, int mode, int limit);
        @(posedge clkDS);
        rst <= 1'b0;
        bitsIn <= '0;
        curCycle = -1;
        testName = name;
        checkLimit = limit;
        fillStimulus(mode);
        @(posedge clkDS);
        @(negedge clkDS);
        checkValue({name, " valid in reset"}, 0, resultValid);
        repeat (RESET_CYCLES - 1) @(posedge clkDS);
        rst <= 1'b1;
        curCycle = 0;
        bitsIn <= stim[0];
    endtask

    task automatic waitForValid(output bit seen);
        int waited;
        waited = 0;
        seen = 1'b0;
        while (!seen && waited < VALID_TIMEOUT) begin
            @(negedge clkDS);
            if (resultValid) begin
                seen = 1'b1;
            end else begin
                driveCycle();
                waited++;
            end
        end
    endtask

    task automatic runPhase(string name, int mode, int limit, int cycles);
        bit seen;
        startPhase(name, mode, limit);
        waitForValid(seen);
        if (!seen) begin
            timeoutCount++;
            $display("Timeout: resultValid_o did not rise in phase %s", name);
        end else begin
            checkValue({name, " latency"}, LATENCY, curCycle);
            while (curCycle < cycles) begin
                driveCycle();
            end
        end
    endtask

    // Output of word t shows up LATENCY cycles after it
    always @(negedge clkDS) begin : compareProc
        int t;
        if (curCycle >= 0) begin
            checkValue({testName, " valid level"}, curCycle >= LATENCY, resultValid);
            t = curCycle - LATENCY;
            if (resultValid && t >= 0 && t < checkLimit) begin
                checkValue($sformatf("%s word %0d", testName, t), expectedResult(t), result);
            end
        end
    end

    initial begin : mainProc
        void'($urandom(31));
        rst <= 1'b0;
        bitsIn <= '0;
        runPhase("zeroStream", MODE_ZERO, 6 * BD, 6 * BD + LATENCY);
        runPhase("impulse", MODE_IMPULSE, 10 * BD, 10 * BD + LATENCY);
        runPhase("randomStream", MODE_RANDOM, 14 * BD, 14 * BD + LATENCY);
        // Reset lands in the middle of a batch
        runPhase("beforeReset", MODE_RANDOM, 3 * BD, LATENCY + 15);
        runPhase("afterReset", MODE_RANDOM, 8 * BD, 8 * BD + LATENCY);
        @(posedge clkDS);
        curCycle = -1;
        $display("Checks: %0d, mismatches: %0d, timeouts: %0d",
                 checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* tests/batchFilter_checker.sv */
`timescale 1ns/1ns
`include "batch_consts.svh"

module batchFilter_checker (
    input logic                 clkDS,
    input logic                 rst,
    input batchSchedPkg::schedT sched_i,
    input logic                 resultValid_i
);
    import batchSchedPkg::*;

    localparam batchIdxT LAST_IDX = batchIdxT'(`BATCH_DEPTH - 1);

    batchIdxT wrIdx;
    slotT     wrSlot;

    assign wrIdx  = sched_i.sampleAddr.wr[`BATCH_W+1:2];
    assign wrSlot = sched_i.sampleAddr.wr[1:0];

    // Valid stays up until the next reset
    validHeld: assert property (@(posedge clkDS) (rst && resultValid_i) |=> resultValid_i)
        else $error("resultValid_o fell while reset was high");

    // Restart pulse sits on the second word of every batch
    restartOnce: assert property (@(posedge clkDS) disable iff (!rst)
        sched_i.lhRestart == (wrIdx == batchIdxT'(1)))
        else $error("lhRestart not exactly once per batch");

    writeStep: assert property (@(posedge clkDS) (rst && wrIdx != LAST_IDX) |=>
        (wrIdx == $past(wrIdx) + batchIdxT'(1)) && (wrSlot == $past(wrSlot)))
        else $error("sample write address did not step within its batch");

    slotStep: assert property (@(posedge clkDS) (rst && wrIdx == LAST_IDX) |=>
        (wrIdx == '0) && (wrSlot == $past(wrSlot) + slotT'(1)))
        else $error("write slot did not advance at batch end");

endmodule

bind batchFilterTop batchFilter_checker i_checker (
    .clkDS(clkDS), .rst(rst), .sched_i(sched), .resultValid_i(resultValid_o)
);

/* design/batchFilterTop.sv */
`timescale 1ns/1ns
`include "batch_consts.svh"

module batchFilterTop (
    input  logic                     clkDS,
    input  logic                     rst,
    input  batchDataPkg::sampleWordT bits_i,
    output batchDataPkg::resultT     result_o,
    output logic                     resultValid_o
);
    import batchDataPkg::*;
    import batchSchedPkg::*;

    localparam int SAMPLE_DEPTH = 2 ** (`BATCH_W + 2);
    localparam int RES_DEPTH    = 2 ** (`BATCH_W + 1);

    // Word t comes out at cycle t + LATENCY. The backward value of the first word of a
    // batch is ready only after the lookahead batch, the compute batch and one reorder batch
    localparam int LATENCY   = 4 * `BATCH_DEPTH + 4;
    // computeValid reaches the channels at cycle 3*BATCH_DEPTH + 1
    localparam int VALID_DLY = LATENCY - 3 * `BATCH_DEPTH - 1;

    schedT      sched;
    sampleWordT lhWord;
    sampleWordT fwdWord;
    sampleWordT bwdWord;
    resultT     fwdRe [`N_CHAN];
    resultT     bwdRe [`N_CHAN];
    resultT     fwdSum;
    resultT     bwdSum;
    resultT     fwdRd;
    resultT     bwdRd;
    logic [VALID_DLY-1:0] validDly;

    batchSchedule scheduler (.clkDS(clkDS), .rst(rst), .sched_o(sched));

    // Three copies of the sample memory, one per read port
    dualPortRam #(.payloadT(sampleWordT), .DEPTH(SAMPLE_DEPTH)) sampleRamLh (
        .clkDS(clkDS), .wrAddr_i(sched.sampleAddr.wr), .wrData_i(bits_i),
        .rdAddr_i(sched.sampleAddr.lhRd), .rdData_o(lhWord)
    );

    dualPortRam #(.payloadT(sampleWordT), .DEPTH(SAMPLE_DEPTH)) sampleRamFwd (
        .clkDS(clkDS), .wrAddr_i(sched.sampleAddr.wr), .wrData_i(bits_i),
        .rdAddr_i(sched.sampleAddr.fwdRd), .rdData_o(fwdWord)
    );

    dualPortRam #(.payloadT(sampleWordT), .DEPTH(SAMPLE_DEPTH)) sampleRamBwd (
        .clkDS(clkDS), .wrAddr_i(sched.sampleAddr.wr), .wrData_i(bits_i),
        .rdAddr_i(sched.sampleAddr.bwdRd), .rdData_o(bwdWord)
    );

    for (genvar c = 0; c < `N_CHAN; c++) begin : chanGen
        channelPath #(.CHAN(c)) chan (
            .clkDS(clkDS), .rst(rst),
            .lhBits_i(lhWord[c]), .fwdBits_i(fwdWord[c]), .bwdBits_i(bwdWord[c]),
            .lhRestart_i(sched.lhRestart), .computeValid_i(sched.computeValid),
            .fwdRe_o(fwdRe[c]), .bwdRe_o(bwdRe[c])
        );
    end

    always_comb begin
        fwdSum = '0;
        bwdSum = '0;
        for (int c = 0; c < `N_CHAN; c++) begin
            fwdSum = fwdSum + fwdRe[c];
            bwdSum = bwdSum + bwdRe[c];
        end
    end

    // B holds the batch in reverse, read back reversed to restore time order
    dualPortRam #(.payloadT(resultT), .DEPTH(RES_DEPTH)) resRamF (
        .clkDS(clkDS), .wrAddr_i(sched.resAddr.wr), .wrData_i(fwdSum),
        .rdAddr_i(sched.resAddr.fwdRd), .rdData_o(fwdRd)
    );

    dualPortRam #(.payloadT(resultT), .DEPTH(RES_DEPTH)) resRamB (
        .clkDS(clkDS), .wrAddr_i(sched.resAddr.wr), .wrData_i(bwdSum),
        .rdAddr_i(sched.resAddr.bwdRd), .rdData_o(bwdRd)
    );

    assign result_o = fwdRd + bwdRd;

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            validDly <= '0;
        end else begin
            validDly <= {validDly[VALID_DLY-2:0], sched.computeValid};
        end
    end

    assign resultValid_o = validDly[VALID_DLY-1];

endmodule

/* design/batchSchedule.sv */
`timescale 1ns/1ns
`include "batch_consts.svh"

module batchSchedule (
    input  logic                 clkDS,
    input  logic                 rst,
    output batchSchedPkg::schedT sched_o
);
    import batchSchedPkg::*;

    localparam int STORE_CNT = 3 * `BATCH_DEPTH;
    // Memory read plus recursion plus weighting register
    localparam int RES_DLY = 3;

    batchIdxT fwdCnt;
    batchIdxT revCnt;
    slotT     wrSlot;
    slotT     lhSlot;
    slotT     idleSlot;
    slotT     cmpSlot;
    logic     batchEnd;

    batchIdxT fwdDly [RES_DLY];
    batchIdxT revDly [RES_DLY];
    logic     ppDly [RES_DLY];

    logic [$clog2(STORE_CNT+1)-1:0] storeCnt;
    logic lhRestart;
    logic computeValid;

    assign batchEnd = (fwdCnt == batchIdxT'(`BATCH_DEPTH - 1));

    // Batch counters and slot rotation, compute trails the write slot by three
    always_ff @(posedge clkDS) begin
        if (!rst) begin
            fwdCnt   <= '0;
            revCnt   <= batchIdxT'(`BATCH_DEPTH - 1);
            wrSlot   <= 2'd0;
            lhSlot   <= 2'd3;
            idleSlot <= 2'd2;
            cmpSlot  <= 2'd1;
        end else if (batchEnd) begin
            fwdCnt   <= '0;
            revCnt   <= batchIdxT'(`BATCH_DEPTH - 1);
            cmpSlot  <= idleSlot;
            idleSlot <= lhSlot;
            lhSlot   <= wrSlot;
            wrSlot   <= wrSlot + 2'd1;
        end else begin
            fwdCnt <= fwdCnt + 1'b1;
            revCnt <= revCnt - 1'b1;
        end
    end

    // Restart lands with the first reversed word out of the memory
    always_ff @(posedge clkDS) begin
        if (!rst) begin
            lhRestart    <= 1'b0;
            storeCnt     <= '0;
            computeValid <= 1'b0;
        end else begin
            lhRestart <= (fwdCnt == '0);
            if (storeCnt != STORE_CNT) begin
                storeCnt <= storeCnt + 1'b1;
            end
            computeValid <= (storeCnt == STORE_CNT);
        end
    end

    // Result addresses follow the channel outputs
    always_ff @(posedge clkDS) begin
        fwdDly[0] <= fwdCnt;
        revDly[0] <= revCnt;
        ppDly[0]  <= wrSlot[0];
        for (int s = 1; s < RES_DLY; s++) begin
            fwdDly[s] <= fwdDly[s-1];
            revDly[s] <= revDly[s-1];
            ppDly[s]  <= ppDly[s-1];
        end
    end

    always_comb begin
        sched_o.sampleAddr.wr    = {fwdCnt, wrSlot};
        sched_o.sampleAddr.lhRd  = {revCnt, lhSlot};
        sched_o.sampleAddr.fwdRd = {fwdCnt, cmpSlot};
        sched_o.sampleAddr.bwdRd = {revCnt, cmpSlot};
        sched_o.resAddr.wr       = {fwdDly[RES_DLY-1], ppDly[RES_DLY-1]};
        // Other ping-pong half holds the previous batch
        sched_o.resAddr.fwdRd    = {fwdDly[RES_DLY-1], ~ppDly[RES_DLY-1]};
        sched_o.resAddr.bwdRd    = {revDly[RES_DLY-1], ~ppDly[RES_DLY-1]};
        sched_o.lhRestart        = lhRestart;
        sched_o.computeValid     = computeValid;
    end

endmodule

/* design/channelPath.sv */
`timescale 1ns/1ns
`include "batch_consts.svh"

module channelPath #(
    parameter int CHAN = 0
) (
    input  logic                 clkDS,
    input  logic                 rst,
    input  logic [`OSR-1:0]      lhBits_i,
    input  logic [`OSR-1:0]      fwdBits_i,
    input  logic [`OSR-1:0]      bwdBits_i,
    input  logic                 lhRestart_i,
    input  logic                 computeValid_i,
    output batchDataPkg::resultT fwdRe_o,
    output batchDataPkg::resultT bwdRe_o
);
    import batchDataPkg::*;

    logic [`OSR-1:0] lhRev;
    logic [`OSR-1:0] bwdRev;
    logic [`OSR-1:0] fwdSel;
    cplxT fwdW [`OSR];
    cplxT bwdW [`OSR];
    cplxT lhIn;
    cplxT fwdIn;
    cplxT bwdIn;
    cplxT lhState;
    cplxT fwdState;
    cplxT bwdState;
    cplxT fwdWeighted;
    cplxT bwdWeighted;

    // Reversed words put the newest bit first
    for (genvar i = 0; i < `OSR; i++) begin : bitGen
        assign lhRev[i]  = lhBits_i[`OSR-1-i];
        assign bwdRev[i] = bwdBits_i[`OSR-1-i];
        assign fwdW[i]   = bitWeight(CHAN, 1'b0, i);
        assign bwdW[i]   = bitWeight(CHAN, 1'b1, i);
    end

    // Memory holds no valid batch yet
    assign fwdSel = computeValid_i ? fwdBits_i : '0;

    bitLut lhLut  (.bits_i(lhRev),  .weights_i(bwdW), .sum_o(lhIn));
    bitLut fwdLut (.bits_i(fwdSel), .weights_i(fwdW), .sum_o(fwdIn));
    bitLut bwdLut (.bits_i(bwdRev), .weights_i(bwdW), .sum_o(bwdIn));

    // Lookahead starts over from zero for each batch
    complexRecursion lhRec (
        .clkDS(clkDS), .rst(rst), .load_i(lhRestart_i), .start_i('0),
        .factor_i(lbPow[CHAN]), .in_i(lhIn), .state_o(lhState)
    );

    // Forward runs from reset without restarts
    complexRecursion fwdRec (
        .clkDS(clkDS), .rst(rst), .load_i(1'b0), .start_i('0),
        .factor_i(lfPow[CHAN]), .in_i(fwdIn), .state_o(fwdState)
    );

    // Backward takes over the finished lookahead of the following batch
    complexRecursion bwdRec (
        .clkDS(clkDS), .rst(rst), .load_i(lhRestart_i), .start_i(lhState),
        .factor_i(lbPow[CHAN]), .in_i(bwdIn), .state_o(bwdState)
    );

    assign fwdWeighted = cmul(wf[CHAN], fwdState);
    assign bwdWeighted = cmul(wb[CHAN], bwdState);

    // Real parts only
    always_ff @(posedge clkDS) begin
        fwdRe_o <= resultT'(fwdWeighted.re);
        bwdRe_o <= resultT'(bwdWeighted.re);
    end

endmodule

/* design/complexRecursion.sv */
`timescale 1ns/1ns

module complexRecursion (
    input  logic               clkDS,
    input  logic               rst,
    input  logic               load_i,
    input  batchDataPkg::cplxT start_i,
    input  batchDataPkg::cplxT factor_i,
    input  batchDataPkg::cplxT in_i,
    output batchDataPkg::cplxT state_o
);
    import batchDataPkg::*;

    cplxT base;
    cplxT nextState;

    // Start value on load, decayed state otherwise
    assign base = load_i ? start_i : cmul(factor_i, state_o);

    assign nextState.re = base.re + in_i.re;
    assign nextState.im = base.im + in_i.im;

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            state_o <= '0;
        end else begin
            state_o <= nextState;
        end
    end

endmodule

/* design/bitLut.sv */
`timescale 1ns/1ns
`include "batch_consts.svh"

module bitLut (
    input  logic [`OSR-1:0]    bits_i,
    input  batchDataPkg::cplxT weights_i [`OSR],
    output batchDataPkg::cplxT sum_o
);
    import batchDataPkg::*;

    cplxT acc;

    // Sum of the weights of all set bits
    always_comb begin
        acc = '0;
        for (int i = 0; i < `OSR; i++) begin
            if (bits_i[i]) begin
                acc.re = acc.re + weights_i[i].re;
                acc.im = acc.im + weights_i[i].im;
            end
        end
    end

    assign sum_o = acc;

endmodule

/* design/dualPortRam.sv */
`timescale 1ns/1ns

module dualPortRam #(
    parameter type payloadT = logic [7:0],
    parameter int  DEPTH    = 16
) (
    input  logic                     clkDS,
    input  logic [$clog2(DEPTH)-1:0] wrAddr_i,
    input  payloadT                  wrData_i,
    input  logic [$clog2(DEPTH)-1:0] rdAddr_i,
    output payloadT                  rdData_o
);

    payloadT mem [DEPTH];

    // Written every cycle, read data one cycle after the address
    always_ff @(posedge clkDS) begin
        mem[wrAddr_i] <= wrData_i;
        rdData_o      <= mem[rdAddr_i];
    end

endmodule

/* design/batchSchedPkg.sv */
`include "batch_consts.svh"

package batchSchedPkg;

    // One of the four rotating sample slots
    typedef logic [1:0] slotT;

    typedef logic [`BATCH_W-1:0] batchIdxT;

    // Batch index above slot
    typedef logic [`BATCH_W+1:0] sampleIdxT;

    // Batch index above ping-pong bit
    typedef logic [`BATCH_W:0] resIdxT;

    typedef struct packed {
        sampleIdxT wr;
        sampleIdxT lhRd;
        sampleIdxT fwdRd;
        sampleIdxT bwdRd;
    } sampleAddrT;

    typedef struct packed {
        resIdxT wr;
        resIdxT fwdRd;
        resIdxT bwdRd;
    } resAddrT;

    typedef struct packed {
        sampleAddrT sampleAddr;
        resAddrT    resAddr;
        logic       lhRestart;
        logic       computeValid;
    } schedT;

endpackage

/* design/batchDataPkg.sv */
`include "batch_consts.svh"

package batchDataPkg;

    localparam int MAX_CHAN = 4;

    // Bit 0 of a channel is the oldest bit
    typedef logic [`N_CHAN-1:0][`OSR-1:0] sampleWordT;

    typedef logic signed [`DATA_W-1:0] partT;

    typedef struct packed {
        partT re;
        partT im;
    } cplxT;

    typedef logic signed [`DATA_W+3:0] resultT;

    // Fixed point constant from thousandths
    function automatic partT fix(int milli);
        return partT'((milli * (1 << `FRAC_W)) / 1000);
    endfunction

    // Product truncated back to FRAC_W fraction bits
    function automatic partT mulTrunc(partT a, partT b);
        logic signed [2*`DATA_W-1:0] prod;
        prod = a * b;
        return partT'(prod >>> `FRAC_W);
    endfunction

    function automatic cplxT cmul(cplxT a, cplxT b);
        cplxT r;
        r.re = mulTrunc(a.re, b.re) - mulTrunc(a.im, b.im);
        r.im = mulTrunc(a.re, b.im) + mulTrunc(a.im, b.re);
        return r;
    endfunction

    // Recursion factors already raised to OSR
    localparam cplxT lfPow [MAX_CHAN] = '{'{fix(781), fix(317)}, '{fix(708), fix(-439)},
                                          '{fix(854), fix(146)}, '{fix(635), fix(537)}};
    localparam cplxT lbPow [MAX_CHAN] = '{'{fix(732), fix(-366)}, '{fix(806), fix(220)},
                                          '{fix(830), fix(-171)}, '{fix(659), fix(513)}};

    // Output weights
    localparam cplxT wf [MAX_CHAN] = '{'{fix(102), fix(-29)}, '{fix(-63), fix(73)},
                                       '{fix(88), fix(41)}, '{fix(-47), fix(-66)}};
    localparam cplxT wb [MAX_CHAN] = '{'{fix(95), fix(34)}, '{fix(-71), fix(-52)},
                                       '{fix(60), fix(-80)}, '{fix(77), fix(45)}};

    // Base bit weights per direction
    localparam cplxT ffBase [MAX_CHAN] = '{'{fix(412), fix(156)}, '{fix(367), fix(-203)},
                                           '{fix(455), fix(88)}, '{fix(298), fix(251)}};
    localparam cplxT fbBase [MAX_CHAN] = '{'{fix(389), fix(-172)}, '{fix(421), fix(119)},
                                           '{fix(350), fix(-95)}, '{fix(310), fix(240)}};

    // dir 0 is forward, 1 is backward; a higher index gets a larger share of the base
    function automatic cplxT bitWeight(int ch, logic dir, int idx);
        cplxT base;
        cplxT w;
        base = dir ? fbBase[ch % MAX_CHAN] : ffBase[ch % MAX_CHAN];
        w.re = partT'((int'(base.re) * (idx + 1)) / `OSR);
        w.im = partT'((int'(base.im) * (idx + 1)) / `OSR);
        return w;
    endfunction

endpackage

/* design/batch_consts.svh */
`ifndef BATCH_CONSTS_SVH
`define BATCH_CONSTS_SVH

// Words per batch, one word per clkDS cycle
`define BATCH_DEPTH 8

// Bits per channel in each word
`define OSR 4

// Channel count, the coefficient tables cover up to four
`define N_CHAN 2

// Signed width of one real or imaginary part
`define DATA_W 18

// Fraction bits of the fixed point format
`define FRAC_W 12

// Width of a batch index
`define BATCH_W $clog2(`BATCH_DEPTH)

`endif
